// ==== filelist.f ====
source/mem_pkg.sv
source/bank_req_if.sv
source/bank_ram.sv
source/bank_array.sv
source/port_router.sv
source/read_return.sv
source/result_dump.sv
source/banked_main_mem.sv
verification/banked_main_mem_tb.sv

// ==== source/bank_array.sv ====
`timescale 1ns/1ps

module bank_array (
    input  logic                       clk,
    bank_req_if.banks                  req,
    input  logic                       dump_active,
    output logic [mem_pkg::WORD_W-1:0] q [mem_pkg::NUM_THREADS-1:0][mem_pkg::LANES-1:0]
);
    import mem_pkg::*;

    for (genvar t = 0; t < NUM_THREADS; t++) begin : g_thread
        for (genvar b = 0; b < LANES; b++) begin : g_bank
            logic [ROW_BITS-1:0] bank_addr;

            // Dump reads the result row of every bank together
            assign bank_addr = dump_active ? RESULT_ROW : req.row[t][b];

            bank_ram u_bank_ram (
                .clk  (clk),
                .we   (req.we[t]),
                .addr (bank_addr),
                .data (req.wdata[t][b]),
                .q    (q[t][b])
            );
        end
    end

endmodule

// ==== source/bank_ram.sv ====
`timescale 1ns/1ps

module bank_ram (
    input  logic                         clk,
    input  logic                         we,
    input  logic [mem_pkg::ROW_BITS-1:0] addr,
    input  logic [mem_pkg::WORD_W-1:0]   data,
    output logic [mem_pkg::WORD_W-1:0]   q
);
    import mem_pkg::*;

    logic [WORD_W-1:0] mem [0:(1 << ROW_BITS) - 1];

    // Write-first, the new word shows on q right away
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
            q         <= data;
        end else begin
            q <= mem[addr];
        end
    end

endmodule

// ==== source/bank_req_if.sv ====
`timescale 1ns/1ps

interface bank_req_if;
    import mem_pkg::*;

    // One write strobe per thread group, shared by its four banks
    logic [NUM_THREADS-1:0] we;
    logic [ROW_BITS-1:0]    row   [NUM_THREADS-1:0][LANES-1:0];
    logic [WORD_W-1:0]      wdata [NUM_THREADS-1:0][LANES-1:0];

    modport router (
        output we, row, wdata
    );

    modport banks (
        input we, row, wdata
    );

endinterface

// ==== source/banked_main_mem.sv ====
`timescale 1ns/1ps

module banked_main_mem (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [mem_pkg::NUM_PORTS-1:0] we_rt,
    input  logic [mem_pkg::NUM_PORTS-1:0] re_rt,
    input  logic [31:0]                   addr_rt     [mem_pkg::NUM_PORTS-1:0],
    input  logic [mem_pkg::LINE_BITS-1:0] data_rt_in  [mem_pkg::NUM_PORTS-1:0],
    input  logic                          re_mc,
    output logic [mem_pkg::LINE_BITS-1:0] data_rt_out [mem_pkg::NUM_PORTS-1:0],
    output logic [mem_pkg::NUM_PORTS-1:0] rd_rdy_rt,
    output logic [mem_pkg::LINE_BITS-1:0] data_mc_out,
    output logic                          rdy_mc
);
    import mem_pkg::*;

    logic [THREAD_BITS-1:0]   tag_thread [NUM_PORTS-1:0];
    logic [$clog2(LANES)-1:0] tag_bank   [NUM_PORTS-1:0][LANES-1:0];
    logic [WORD_W-1:0]        q          [NUM_THREADS-1:0][LANES-1:0];
    logic                     dump_active;

    bank_req_if req_if ();

    port_router u_port_router (
        .clk        (clk),
        .rst_n      (rst_n),
        .we_rt      (we_rt),
        .re_rt      (re_rt),
        .addr_rt    (addr_rt),
        .data_rt_in (data_rt_in),
        .req        (req_if.router),
        .tag_thread (tag_thread),
        .tag_bank   (tag_bank)
    );

    bank_array u_bank_array (
        .clk         (clk),
        .req         (req_if.banks),
        .dump_active (dump_active),
        .q           (q)
    );

    read_return u_read_return (
        .clk         (clk),
        .rst_n       (rst_n),
        .re_rt       (re_rt),
        .tag_thread  (tag_thread),
        .tag_bank    (tag_bank),
        .q           (q),
        .data_rt_out (data_rt_out),
        .rd_rdy_rt   (rd_rdy_rt)
    );

    result_dump u_result_dump (
        .clk         (clk),
        .rst_n       (rst_n),
        .re_mc       (re_mc),
        .q           (q),
        .dump_active (dump_active),
        .data_mc_out (data_mc_out),
        .rdy_mc      (rdy_mc)
    );

endmodule

// ==== source/mem_pkg.sv ====
package mem_pkg;

    // Memory geometry
    localparam int NUM_PORTS   = 4;
    localparam int NUM_THREADS = 8;
    localparam int THREAD_BITS = 3;
    localparam int LANES       = 4;
    localparam int ROW_BITS    = 8;
    localparam int WORD_BITS   = ROW_BITS + 2;

    // Thread field position in the byte address
    localparam int THREAD_LSB  = 16;

    // Row the memory controller dumps
    localparam logic [ROW_BITS-1:0] RESULT_ROW = '1;

    localparam int LINE_BITS   = 128;
    localparam int WORD_W      = 32;

    // Dump FSM states
    localparam logic [1:0] DUMP_IDLE  = 2'd0;
    localparam logic [1:0] DUMP_WAIT1 = 2'd1;
    localparam logic [1:0] DUMP_WAIT2 = 2'd2;
    localparam logic [1:0] DUMP_READ  = 2'd3;

endpackage

// ==== source/port_router.sv ====
`timescale 1ns/1ps

module port_router (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [mem_pkg::NUM_PORTS-1:0]     we_rt,
    input  logic [mem_pkg::NUM_PORTS-1:0]     re_rt,
    input  logic [31:0]                       addr_rt    [mem_pkg::NUM_PORTS-1:0],
    input  logic [mem_pkg::LINE_BITS-1:0]     data_rt_in [mem_pkg::NUM_PORTS-1:0],
    bank_req_if.router                        req,
    output logic [mem_pkg::THREAD_BITS-1:0]   tag_thread [mem_pkg::NUM_PORTS-1:0],
    output logic [$clog2(mem_pkg::LANES)-1:0] tag_bank
                                              [mem_pkg::NUM_PORTS-1:0][mem_pkg::LANES-1:0]
);
    import mem_pkg::*;

    // Decoded requests ahead of stage 0
    logic [THREAD_BITS-1:0]   thread_in [NUM_PORTS-1:0];
    logic [ROW_BITS-1:0]      row_in    [NUM_PORTS-1:0][LANES-1:0];
    logic [WORD_W-1:0]        data_in   [NUM_PORTS-1:0][LANES-1:0];
    logic [$clog2(LANES)-1:0] bank_in   [NUM_PORTS-1:0][LANES-1:0];
    logic [NUM_THREADS-1:0]   we_in;

    // Stage 0 registers
    logic [NUM_PORTS-1:0]     act_0;
    logic [NUM_THREADS-1:0]   we_0;
    logic [ROW_BITS-1:0]      row_0  [NUM_PORTS-1:0][LANES-1:0];
    logic [WORD_W-1:0]        data_0 [NUM_PORTS-1:0][LANES-1:0];

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        logic [WORD_BITS-1:0]     idx;
        logic [$clog2(LANES)-1:0] first;

        assign idx          = addr_rt[p][2 +: WORD_BITS];
        assign first        = idx[$clog2(LANES)-1:0];
        assign thread_in[p] = addr_rt[p][THREAD_LSB +: THREAD_BITS];

        for (genvar b = 0; b < LANES; b++) begin : g_lane
            logic [WORD_BITS-1:0] k;
            logic [WORD_BITS-1:0] lane_idx;
            logic [WORD_BITS-1:0] word_idx;

            // Line word k lands in bank b
            assign k        = WORD_BITS'((b + LANES - first) % LANES);
            assign lane_idx = idx + k;
            assign row_in[p][b]  = lane_idx[WORD_BITS-1:$clog2(LANES)];
            assign data_in[p][b] = data_rt_in[p][k*WORD_W +: WORD_W];

            // Bank holding line word b, used to put the line back together
            assign word_idx      = idx + WORD_BITS'(b);
            assign bank_in[p][b] = word_idx[$clog2(LANES)-1:0];
        end
    end

    // Colliding writes to one group still raise its strobe
    always_comb begin
        we_in = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (we_rt[p]) begin
                we_in[thread_in[p]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_0 <= '0;
            we_0  <= '0;
        end else begin
            act_0 <= we_rt | re_rt;
            we_0  <= we_in;
        end
    end

    always_ff @(posedge clk) begin
        tag_thread <= thread_in;
        tag_bank   <= bank_in;
        row_0      <= row_in;
        data_0     <= data_in;
    end

    // Stage 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.we <= '0;
        end else begin
            req.we <= we_0;
        end
    end

    // Walk ports from high to low so the lowest index is assigned last and wins
    always_ff @(posedge clk) begin
        for (int t = 0; t < NUM_THREADS; t++) begin
            for (int p = NUM_PORTS - 1; p >= 0; p--) begin
                if (act_0[p] && tag_thread[p] == t) begin
                    req.row[t]   <= row_0[p];
                    req.wdata[t] <= data_0[p];
                end
            end
        end
    end

endmodule

// ==== source/read_return.sv ====
`timescale 1ns/1ps

module read_return (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [mem_pkg::NUM_PORTS-1:0]     re_rt,
    input  logic [mem_pkg::THREAD_BITS-1:0]   tag_thread [mem_pkg::NUM_PORTS-1:0],
    input  logic [$clog2(mem_pkg::LANES)-1:0] tag_bank
                                              [mem_pkg::NUM_PORTS-1:0][mem_pkg::LANES-1:0],
    input  logic [mem_pkg::WORD_W-1:0]        q [mem_pkg::NUM_THREADS-1:0][mem_pkg::LANES-1:0],
    output logic [mem_pkg::LINE_BITS-1:0]     data_rt_out [mem_pkg::NUM_PORTS-1:0],
    output logic [mem_pkg::NUM_PORTS-1:0]     rd_rdy_rt
);
    import mem_pkg::*;

    logic [NUM_PORTS-1:0]     re_0;
    logic [NUM_PORTS-1:0]     re_1;
    logic [NUM_PORTS-1:0]     re_2;
    logic [THREAD_BITS-1:0]   thread_1 [NUM_PORTS-1:0];
    logic [THREAD_BITS-1:0]   thread_2 [NUM_PORTS-1:0];
    logic [$clog2(LANES)-1:0] bank_1   [NUM_PORTS-1:0][LANES-1:0];
    logic [$clog2(LANES)-1:0] bank_2   [NUM_PORTS-1:0][LANES-1:0];
    logic [$clog2(LANES)-1:0] bank_3   [NUM_PORTS-1:0][LANES-1:0];
    logic [WORD_W-1:0]        lane_3   [NUM_PORTS-1:0][LANES-1:0];

    // Ready follows the request through all four stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            re_0      <= '0;
            re_1      <= '0;
            re_2      <= '0;
            rd_rdy_rt <= '0;
        end else begin
            re_0      <= re_rt;
            re_1      <= re_0;
            re_2      <= re_1;
            rd_rdy_rt <= re_2;
        end
    end

    // Tags arrive after stage 0
    always_ff @(posedge clk) begin
        thread_1 <= tag_thread;
        thread_2 <= thread_1;
        bank_1   <= tag_bank;
        bank_2   <= bank_1;
        bank_3   <= bank_2;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int b = 0; b < LANES; b++) begin
                lane_3[p][b] <= q[thread_2[p]][b];
            end
        end
    end

    // Un-rotate lanes into line order
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k < LANES; k++) begin
                data_rt_out[p][k*WORD_W +: WORD_W] = lane_3[p][bank_3[p][k]];
            end
        end
    end

endmodule

// ==== source/result_dump.sv ====
`timescale 1ns/1ps

module result_dump (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          re_mc,
    input  logic [mem_pkg::WORD_W-1:0]    q [mem_pkg::NUM_THREADS-1:0][mem_pkg::LANES-1:0],
    output logic                          dump_active,
    output logic [mem_pkg::LINE_BITS-1:0] data_mc_out,
    output logic                          rdy_mc
);
    import mem_pkg::*;

    logic [1:0]             state;
    logic [1:0]             nxt_state;
    logic [THREAD_BITS-1:0] thread_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DUMP_IDLE;
        end else begin
            state <= nxt_state;
        end
    end

    // One thread group per read cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            thread_cnt <= '0;
        end else if (state == DUMP_READ) begin
            thread_cnt <= thread_cnt + 1'b1;
        end else begin
            thread_cnt <= '0;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            DUMP_IDLE: begin
                if (re_mc) begin
                    nxt_state = DUMP_WAIT1;
                end
            end
            DUMP_WAIT1: nxt_state = DUMP_WAIT2;
            DUMP_WAIT2: nxt_state = DUMP_READ;
            default: begin
                if (thread_cnt == THREAD_BITS'(NUM_THREADS - 1)) begin
                    nxt_state = DUMP_IDLE;
                end
            end
        endcase
    end

    // Banks are forced one cycle early so q holds the result row on the first read
    assign dump_active = (state == DUMP_WAIT2) || (state == DUMP_READ);
    assign rdy_mc      = (state == DUMP_READ);

    always_comb begin
        data_mc_out = '0;
        if (rdy_mc) begin
            for (int j = 0; j < LANES; j++) begin
                data_mc_out[j*WORD_W +: WORD_W] = q[thread_cnt][j];
            end
        end
    end

endmodule

// ==== verification/banked_main_mem_tb.sv ====
`timescale 1ns/1ps

module banked_main_mem_tb;
    import mem_pkg::*;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [NUM_PORTS-1:0] we_rt;
    logic [NUM_PORTS-1:0] re_rt;
    logic [31:0]          addr_rt     [NUM_PORTS-1:0];
    logic [LINE_BITS-1:0] data_rt_in  [NUM_PORTS-1:0];
    logic                 re_mc;
    logic [LINE_BITS-1:0] data_rt_out [NUM_PORTS-1:0];
    logic [NUM_PORTS-1:0] rd_rdy_rt;
    logic [LINE_BITS-1:0] data_mc_out;
    logic                 rdy_mc;

    // Word-addressed reference memory, one word index space per thread group
    logic [WORD_W-1:0]    ref_mem    [NUM_THREADS][1 << WORD_BITS];
    logic [31:0]          stage_addr [NUM_PORTS];
    logic [LINE_BITS-1:0] stage_line [NUM_PORTS];

    // Expected read returns, slot picked by due cycle
    int                   exp_due    [NUM_PORTS][8];
    logic [LINE_BITS-1:0] exp_line   [NUM_PORTS][8];
    int                   last_due    = -1;
    int                   cycle_count = 0;

    banked_main_mem dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .we_rt       (we_rt),
        .re_rt       (re_rt),
        .addr_rt     (addr_rt),
        .data_rt_in  (data_rt_in),
        .re_mc       (re_mc),
        .data_rt_out (data_rt_out),
        .rd_rdy_rt   (rd_rdy_rt),
        .data_mc_out (data_mc_out),
        .rdy_mc      (rdy_mc)
    );

    always #5 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [LINE_BITS-1:0] expected,
                               input logic [LINE_BITS-1:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // Tests take well under 250 cycles, so 4000 leaves plenty of margin
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == 4000) begin
            stop_on_error("timeout: the run did not finish within 4000 cycles");
        end
    end

    // Read return monitor
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (exp_due[p][cycle_count % 8] == cycle_count) begin
                    check_value($sformatf("read ready port %0d", p), 1, rd_rdy_rt[p]);
                    check_value($sformatf("read data port %0d", p),
                                exp_line[p][cycle_count % 8], data_rt_out[p]);
                end else begin
                    check_value($sformatf("unexpected ready port %0d", p), 0, rd_rdy_rt[p]);
                end
            end
        end
    end

    function automatic logic [31:0] make_addr(input int thread, input int idx);
        return (32'(thread) << THREAD_LSB) | (32'(idx % (1 << WORD_BITS)) << 2);
    endfunction

    function automatic logic [LINE_BITS-1:0] rand_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic logic [LINE_BITS-1:0] model_read(input logic [31:0] addr);
        logic [WORD_BITS-1:0]   w;
        logic [THREAD_BITS-1:0] t;
        logic [LINE_BITS-1:0]   line;
        t = addr[THREAD_LSB +: THREAD_BITS];
        for (int k = 0; k < LANES; k++) begin
            w = addr[2 +: WORD_BITS] + WORD_BITS'(k);
            line[k*WORD_W +: WORD_W] = ref_mem[t][w];
        end
        return line;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [LINE_BITS-1:0] line);
        logic [WORD_BITS-1:0]   w;
        logic [THREAD_BITS-1:0] t;
        t = addr[THREAD_LSB +: THREAD_BITS];
        for (int k = 0; k < LANES; k++) begin
            w = addr[2 +: WORD_BITS] + WORD_BITS'(k);
            ref_mem[t][w] = line[k*WORD_W +: WORD_W];
        end
    endtask

    // Drive staged requests for one cycle and update the model
    task automatic issue(input logic [NUM_PORTS-1:0] we, input logic [NUM_PORTS-1:0] re);
        int   winner;
        logic any_we;
        int   slot;
        @(negedge clk);
        we_rt = we;
        re_rt = re;
        for (int p = 0; p < NUM_PORTS; p++) begin
            addr_rt[p]    = stage_addr[p];
            data_rt_in[p] = stage_line[p];
            if (re[p]) begin
                slot              = (cycle_count + 4) % 8;
                exp_due[p][slot]  = cycle_count + 4;
                exp_line[p][slot] = model_read(stage_addr[p]);
                last_due          = cycle_count + 4;
            end
        end
        // Lowest active port owns the group, any writer raises the strobe
        for (int t = 0; t < NUM_THREADS; t++) begin
            winner = -1;
            any_we = 1'b0;
            for (int p = NUM_PORTS - 1; p >= 0; p--) begin
                if ((we[p] || re[p]) && stage_addr[p][THREAD_LSB +: THREAD_BITS] == t) begin
                    winner = p;
                    any_we = any_we | we[p];
                end
            end
            if (any_we) begin
                model_write(stage_addr[winner], stage_line[winner]);
            end
        end
    endtask

    task automatic go_idle();
        @(negedge clk);
        we_rt = '0;
        re_rt = '0;
    endtask

    task automatic wait_reads_done();
        int n;
        n = 0;
        while (cycle_count <= last_due) begin
            if (n == 16) begin
                stop_on_error("read results still pending 16 cycles after the last read");
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic check_idle_after_reset();
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value("reset read ready", 0, rd_rdy_rt);
            check_value("reset dump ready", 0, rdy_mc);
            check_value("reset dump data", 0, data_mc_out);
        end
    endtask

    task automatic single_port_lines();
        // Start banks 0 to 3, a row crossing and a wrap of the word index
        int idx_list [6] = '{32, 65, 98, 131, 43, 1022};
        int n;
        for (int i = 0; i < 6; i++) begin
            stage_addr[0] = make_addr(3, idx_list[i]) | 32'(i % 4);
            stage_line[0] = rand_line();
            issue(4'b0001, 4'b0000);
        end
        go_idle();
        for (int i = 0; i < 6; i++) begin
            stage_addr[0] = make_addr(3, idx_list[i]);
            issue(4'b0000, 4'b0001);
            go_idle();
            n = 1;
            while (!rd_rdy_rt[0] && n < 12) begin
                @(negedge clk);
                n++;
            end
            if (!rd_rdy_rt[0]) begin
                stop_on_error("single port read never raised its ready");
            end
            check_value("single port read latency", 4, n);
            @(negedge clk);
            check_value("single port ready width", 0, rd_rdy_rt[0]);
        end
    endtask

    task automatic parallel_ports();
        logic [31:0] round_addr [8][NUM_PORTS];
        for (int r = 0; r < 8; r++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                round_addr[r][p] = $urandom;
                round_addr[r][p][THREAD_LSB +: THREAD_BITS] = THREAD_BITS'((r + p) % NUM_THREADS);
                stage_addr[p] = round_addr[r][p];
                stage_line[p] = rand_line();
            end
            issue(4'b1111, 4'b0000);
        end
        for (int r = 0; r < 8; r++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                stage_addr[p] = round_addr[r][p];
            end
            issue(4'b0000, 4'b1111);
        end
        go_idle();
        wait_reads_done();
    endtask

    task automatic port_collision();
        stage_addr[3] = make_addr(5, 200);
        stage_line[3] = rand_line();
        issue(4'b1000, 4'b0000);
        // Ports 1 and 3 hit group 5 together, port 0 writes group 2
        stage_addr[0] = make_addr(2, 10);
        stage_line[0] = rand_line();
        stage_addr[1] = make_addr(5, 77);
        stage_line[1] = rand_line();
        stage_line[3] = rand_line();
        issue(4'b1011, 4'b0000);
        stage_addr[2] = make_addr(5, 77);
        issue(4'b0000, 4'b0101);
        stage_addr[2] = make_addr(5, 200);
        issue(4'b0000, 4'b0100);
        go_idle();
        wait_reads_done();
    endtask

    task automatic result_dump_sequence();
        int n;
        for (int t = 0; t < NUM_THREADS; t++) begin
            stage_addr[t % NUM_PORTS] = make_addr(t, int'(RESULT_ROW) * LANES);
            stage_line[t % NUM_PORTS] = rand_line();
            if (t % NUM_PORTS == NUM_PORTS - 1) begin
                issue(4'b1111, 4'b0000);
            end
        end
        go_idle();
        repeat (4) @(negedge clk);
        re_mc = 1'b1;
        @(negedge clk);
        re_mc = 1'b0;
        n = 1;
        while (!rdy_mc && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!rdy_mc) begin
            stop_on_error("dump ready never rose after the request");
        end
        check_value("dump start latency", 3, n);
        for (int g = 0; g < NUM_THREADS; g++) begin
            if (g > 0) begin
                @(negedge clk);
            end
            check_value($sformatf("dump ready group %0d", g), 1, rdy_mc);
            check_value($sformatf("dump data group %0d", g),
                        model_read(make_addr(g, int'(RESULT_ROW) * LANES)), data_mc_out);
            // A request in the middle of a dump must not start another
            re_mc = (g == 3);
        end
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            check_value("dump ready after end", 0, rdy_mc);
            check_value("dump data after end", 0, data_mc_out);
        end
    endtask

    initial begin
        void'($urandom(14990));
        rst_n = 1'b0;
        we_rt = '0;
        re_rt = '0;
        re_mc = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            addr_rt[p]    = '0;
            data_rt_in[p] = '0;
            stage_addr[p] = '0;
            stage_line[p] = '0;
            for (int s = 0; s < 8; s++) begin
                exp_due[p][s]  = -1;
                exp_line[p][s] = '0;
            end
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        check_idle_after_reset();
        single_port_lines();
        parallel_ports();
        port_collision();
        result_dump_sequence();

        $display("NO ERRORS");
        $finish;
    end

endmodule
